// ==== common/dp_hpd_pkg.sv ====
////////////////////
// DP HPD shared definitions
// Local bus widths and block map, HPD control bit positions,
// counter widths and the HPD generator state type
////////////////////

`default_nettype none

package dp_hpd_pkg;

    // Local bus
    parameter int LB_ADR_W = 4;                 // [3:2] block, [1:0] register
    parameter int LB_DAT_W = 32;

    // Block map on address bits 3 and 2
    parameter logic [1:0] LB_BLK_HPD  = 2'd0;   // HPD generator
    parameter logic [1:0] LB_BLK_BEAT = 2'd1;   // Beat prescaler
    // Blocks 2 and 3 unmapped

    // Returned on unmapped or unused addresses
    parameter logic [LB_DAT_W-1:0] LB_RD_DEFAULT = 32'hdeadcafe;

    // HPD control register bits
    parameter int CTL_RUN    = 0;               // Enable
    parameter int CTL_UNPLUG = 1;               // Drop HPD, self clearing
    parameter int CTL_PLUG   = 2;               // Raise HPD, self clearing
    parameter int CTL_PULSE  = 3;               // IRQ pulse, self clearing
    parameter int CTL_W      = 4;

    // Beat divisor register
    parameter int BEAT_DIV_W = 16;

    // HPD interval counter, in beats
    parameter int HPD_CNT_W = 18;

    // HPD generator states
    typedef enum logic [1:0]
    {
        HPD_RST,                                // Pin held low
        HPD_IDLE,                               // Waits for plug, unplug or pulse
        HPD_PULSE                               // IRQ low pulse running
    } hpd_state_e;

endpackage

`default_nettype wire

// ==== rtl/lb_decoder.sv ====
////////////////////
// Local bus decoder
// Registers the host bus once, decodes the block field
// into selects and returns read data one cycle after the read
////////////////////

`timescale 1ns/1ps
`default_nettype none

module lb_decoder
(
    input wire                                  CLK_IN,
    input wire                                  RST_IN,

    // Host side
    input wire [dp_hpd_pkg::LB_ADR_W-1:0]       lb_adr,
    input wire                                  lb_wr,
    input wire                                  lb_rd,
    input wire [dp_hpd_pkg::LB_DAT_W-1:0]       lb_din,
    output logic [dp_hpd_pkg::LB_DAT_W-1:0]     lb_dout,
    output logic                                lb_vld,

    // Block side
    output logic [1:0]                          reg_adr,    // Register inside block
    output logic                                reg_wr,
    output logic [dp_hpd_pkg::LB_DAT_W-1:0]     reg_din,
    output logic                                hpd_sel,
    output logic                                beat_sel,
    input wire [dp_hpd_pkg::LB_DAT_W-1:0]       hpd_rdata,
    input wire [dp_hpd_pkg::LB_DAT_W-1:0]       beat_rdata
);

    import dp_hpd_pkg::*;

    logic [LB_ADR_W-1:0]    adr_r;
    logic [LB_DAT_W-1:0]    din_r;
    logic                   wr_r;
    logic                   rd_r;
    logic [1:0]             blk;                // Block field

    // Strobes
    always_ff @ (posedge CLK_IN, posedge RST_IN)
    begin
        if (RST_IN)
        begin
            wr_r <= 1'b0;
            rd_r <= 1'b0;
        end
        else
        begin
            wr_r <= lb_wr;
            rd_r <= lb_rd;
        end
    end

    // Address and write data
    always_ff @ (posedge CLK_IN)
    begin
        adr_r <= lb_adr;
        din_r <= lb_din;
    end

    assign blk      = adr_r[LB_ADR_W-1 -: 2];
    assign hpd_sel  = (blk == LB_BLK_HPD);
    assign beat_sel = (blk == LB_BLK_BEAT);

    // To the blocks
    assign reg_adr  = adr_r[1:0];
    assign reg_wr   = wr_r;
    assign reg_din  = din_r;

    // Read mux
    always_comb
    begin
        if (hpd_sel)
            lb_dout = hpd_rdata;
        else if (beat_sel)
            lb_dout = beat_rdata;
        else
            lb_dout = LB_RD_DEFAULT;            // Unmapped block
    end

    assign lb_vld = rd_r;                       // One cycle after lb_rd

endmodule

`default_nettype wire

// ==== rtl/beat_gen.sv ====
////////////////////
// Beat prescaler
// Divides the clock down to a one-cycle beat pulse
// Divisor register sits at register 0 of its block
////////////////////

`timescale 1ns/1ps
`default_nettype none

module beat_gen
#(
    parameter int unsigned P_BEAT_DIV = 99      // Reset divisor, beat every D+1 clocks
)
(
    input wire                                  CLK_IN,
    input wire                                  RST_IN,

    // Register side from the decoder
    input wire                                  sel,        // Block selected
    input wire [1:0]                            reg_adr,
    input wire                                  reg_wr,
    input wire [dp_hpd_pkg::LB_DAT_W-1:0]       reg_din,
    output logic [dp_hpd_pkg::LB_DAT_W-1:0]     rdata,

    output logic                                beat        // One-cycle pulse
);

    import dp_hpd_pkg::*;

    logic [BEAT_DIV_W-1:0]  div;                // Divisor register
    logic [BEAT_DIV_W-1:0]  cnt;                // Down counter
    logic                   div_wr;

    assign div_wr = sel && reg_wr && (reg_adr == 2'd0);

    // Divisor register
    always_ff @ (posedge CLK_IN, posedge RST_IN)
    begin
        if (RST_IN)
            div <= BEAT_DIV_W'(P_BEAT_DIV);
        else if (div_wr)
            div <= reg_din[BEAT_DIV_W-1:0];
    end

    // Counter and beat
    always_ff @ (posedge CLK_IN, posedge RST_IN)
    begin
        if (RST_IN)
        begin
            cnt  <= '0;
            beat <= 1'b0;
        end
        else if (div_wr)
        begin
            cnt  <= reg_din[BEAT_DIV_W-1:0];    // Restart with new divisor
            beat <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= div;                        // Reload
            beat <= (div != '0);                // Zero divisor stops the beat
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            beat <= 1'b0;
        end
    end

    // Readback
    always_comb
    begin
        if (reg_adr == 2'd0)
            rdata = {{(LB_DAT_W-BEAT_DIV_W){1'b0}}, div};   // Zero extended
        else
            rdata = LB_RD_DEFAULT;
    end

endmodule

`default_nettype wire

// ==== hpd/hpd_gen.sv ====
////////////////////
// HPD generator
// Control register, state machine and beat timed interval
// counter driving the sink HPD pin. Handles plug, unplug
// and IRQ low pulse with a minimum spacing after each rise
////////////////////

`timescale 1ns/1ps
`default_nettype none

module hpd_gen
#(
    parameter int unsigned P_HMS_BEATS = 2000,  // Minimum spacing after a rising edge
    parameter int unsigned P_IPW_BEATS = 500    // IRQ pulse width
)
(
    input wire                                  CLK_IN,
    input wire                                  RST_IN,

    // Register side from the decoder
    input wire                                  sel,
    input wire [1:0]                            reg_adr,
    input wire                                  reg_wr,
    input wire [dp_hpd_pkg::LB_DAT_W-1:0]       reg_din,
    input wire                                  beat,       // From the prescaler
    output logic [dp_hpd_pkg::LB_DAT_W-1:0]     rdata,

    output logic                                hpd
);

    import dp_hpd_pkg::*;

    // Control
    logic [CTL_W-1:0]       ctl_r;
    logic                   ctl_sel;
    logic                   run;
    logic                   unplug;
    logic                   plug;
    logic                   pulse;
    logic                   unplug_clr;
    logic                   plug_clr;
    logic                   pulse_clr;

    // State machine
    hpd_state_e             state_cur;
    hpd_state_e             state_nxt;

    // Beat edge
    logic                   beat_d;
    logic                   beat_re;

    // Interval counter and pin
    logic [HPD_CNT_W-1:0]   cnt;
    logic [HPD_CNT_W-1:0]   cnt_in;
    logic                   cnt_ld;
    logic                   cnt_end;
    logic                   pin;
    logic                   pin_set;
    logic                   pin_clr;

    assign ctl_sel = sel && (reg_adr == 2'd0);

    // Control register, bus write wins over the event clears
    always_ff @ (posedge CLK_IN, posedge RST_IN)
    begin
        if (RST_IN)
            ctl_r <= '0;
        else if (ctl_sel && reg_wr)
            ctl_r <= reg_din[CTL_W-1:0];
        else if (unplug_clr)
            ctl_r[CTL_UNPLUG] <= 1'b0;
        else if (plug_clr)
            ctl_r[CTL_PLUG] <= 1'b0;
        else if (pulse_clr)
            ctl_r[CTL_PULSE] <= 1'b0;
    end

    assign run    = ctl_r[CTL_RUN];
    assign unplug = ctl_r[CTL_UNPLUG];
    assign plug   = ctl_r[CTL_PLUG];
    assign pulse  = ctl_r[CTL_PULSE];

    // Readback
    always_comb
    begin
        if (reg_adr == 2'd0)
            rdata = {{(LB_DAT_W-CTL_W){1'b0}}, ctl_r};
        else
            rdata = LB_RD_DEFAULT;
    end

    // Beat rising edge
    always_ff @ (posedge CLK_IN, posedge RST_IN)
    begin
        if (RST_IN)
            beat_d <= 1'b0;
        else
            beat_d <= beat;
    end

    assign beat_re = beat && !beat_d;

    // State register, held in reset while run is clear
    always_ff @ (posedge CLK_IN, posedge RST_IN)
    begin
        if (RST_IN)
            state_cur <= HPD_RST;
        else if (run)
            state_cur <= state_nxt;
        else
            state_cur <= HPD_RST;
    end

    // Next state and actions
    always_comb
    begin
        cnt_ld     = 1'b0;
        cnt_in     = '0;
        pin_set    = 1'b0;
        pin_clr    = 1'b0;
        unplug_clr = 1'b0;
        plug_clr   = 1'b0;
        pulse_clr  = 1'b0;
        state_nxt  = HPD_RST;

        case (state_cur)
            HPD_RST :
            begin
                pin_clr   = 1'b1;
                state_nxt = HPD_IDLE;
            end

            HPD_IDLE :
            begin
                state_nxt = HPD_IDLE;

                // Unplug once spacing has passed
                if (unplug && cnt_end)
                begin
                    unplug_clr = 1'b1;
                    pin_clr    = 1'b1;
                end
                else if (plug)
                begin
                    plug_clr = 1'b1;
                    pin_set  = 1'b1;
                    cnt_ld   = 1'b1;
                    cnt_in   = HPD_CNT_W'(P_HMS_BEATS);   // Start spacing
                end
                // IRQ pulse, also waits for spacing
                else if (pulse && cnt_end)
                begin
                    pulse_clr = 1'b1;
                    pin_clr   = 1'b1;
                    cnt_ld    = 1'b1;
                    cnt_in    = HPD_CNT_W'(P_IPW_BEATS);   // Pulse width
                    state_nxt = HPD_PULSE;
                end
            end

            HPD_PULSE :
            begin
                if (cnt_end)
                begin
                    pin_set   = 1'b1;                      // Rising edge again
                    cnt_ld    = 1'b1;
                    cnt_in    = HPD_CNT_W'(P_HMS_BEATS);
                    state_nxt = HPD_IDLE;
                end
                else
                    state_nxt = HPD_PULSE;
            end

            default : state_nxt = HPD_RST;
        endcase
    end

    // Interval counter, one step per beat
    always_ff @ (posedge CLK_IN, posedge RST_IN)
    begin
        if (RST_IN)
            cnt <= '0;
        else if (!run)
            cnt <= '0;                          // Idle
        else if (cnt_ld)
            cnt <= cnt_in;
        else if (!cnt_end && beat_re)
            cnt <= cnt - 1'b1;
    end

    assign cnt_end = (cnt == '0);

    // HPD pin, clear has priority
    always_ff @ (posedge CLK_IN, posedge RST_IN)
    begin
        if (RST_IN)
            pin <= 1'b0;
        else if (!run)
            pin <= 1'b0;
        else if (pin_clr)
            pin <= 1'b0;
        else if (pin_set)
            pin <= 1'b1;
    end

    assign hpd = pin;

endmodule

`default_nettype wire

// ==== rtl/dp_hpd_top.sv ====
////////////////////
// DP sink HPD top level
// Local bus decoder, beat prescaler and HPD generator
////////////////////

`timescale 1ns/1ps
`default_nettype none

module dp_hpd_top
#(
    parameter int unsigned P_BEAT_DIV  = 99,    // Clocks per beat minus one
    parameter int unsigned P_HMS_BEATS = 2000,  // Minimum spacing in beats
    parameter int unsigned P_IPW_BEATS = 500    // IRQ pulse width in beats
)
(
    input wire                                  CLK_IN,
    input wire                                  RST_IN,

    // Local bus from the host
    input wire [dp_hpd_pkg::LB_ADR_W-1:0]       lb_adr,
    input wire                                  lb_wr,
    input wire                                  lb_rd,
    input wire [dp_hpd_pkg::LB_DAT_W-1:0]       lb_din,
    output logic [dp_hpd_pkg::LB_DAT_W-1:0]     lb_dout,
    output logic                                lb_vld,

    output logic                                hpd         // Sink HPD pin
);

    import dp_hpd_pkg::*;

    logic [1:0]             reg_adr;
    logic                   reg_wr;
    logic [LB_DAT_W-1:0]    reg_din;
    logic                   hpd_sel;
    logic                   beat_sel;
    logic [LB_DAT_W-1:0]    hpd_rdata;
    logic [LB_DAT_W-1:0]    beat_rdata;
    logic                   beat;

    // Bus decode and read mux
    lb_decoder u_lb_decoder
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .lb_adr     (lb_adr),
        .lb_wr      (lb_wr),
        .lb_rd      (lb_rd),
        .lb_din     (lb_din),
        .lb_dout    (lb_dout),
        .lb_vld     (lb_vld),
        .reg_adr    (reg_adr),
        .reg_wr     (reg_wr),
        .reg_din    (reg_din),
        .hpd_sel    (hpd_sel),
        .beat_sel   (beat_sel),
        .hpd_rdata  (hpd_rdata),
        .beat_rdata (beat_rdata)
    );

    // Beat, stands in for the 1 MHz beat
    beat_gen #(.P_BEAT_DIV(P_BEAT_DIV)) u_beat_gen
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .sel        (beat_sel),
        .reg_adr    (reg_adr),
        .reg_wr     (reg_wr),
        .reg_din    (reg_din),
        .rdata      (beat_rdata),
        .beat       (beat)
    );

    // HPD generator
    hpd_gen #(.P_HMS_BEATS(P_HMS_BEATS), .P_IPW_BEATS(P_IPW_BEATS)) u_hpd_gen
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .sel        (hpd_sel),
        .reg_adr    (reg_adr),
        .reg_wr     (reg_wr),
        .reg_din    (reg_din),
        .beat       (beat),
        .rdata      (hpd_rdata),
        .hpd        (hpd)
    );

endmodule

`default_nettype wire

// ==== test/hpd_gen_properties.sv ====
////////////////////
// HPD generator assertions
// Pin off without run, pulse exit on counter end,
// interval counter only rises on a load
////////////////////

`timescale 1ns/1ps
`default_nettype none

module hpd_gen_properties
(
    input wire                                  CLK_IN,
    input wire                                  RST_IN,
    input wire                                  run,
    input wire                                  hpd,
    input var dp_hpd_pkg::hpd_state_e           state_cur,
    input wire [dp_hpd_pkg::HPD_CNT_W-1:0]      cnt,
    input wire                                  cnt_ld,
    input wire                                  cnt_end
);

    import dp_hpd_pkg::*;

    // Pin register follows run one edge later
    a_hpd_off : assert property (@(posedge CLK_IN) disable iff (RST_IN)
        !run |=> !hpd)
        else $error("hpd high while run is clear");

    // Pulse state held until the counter ends
    a_pulse_exit : assert property (@(posedge CLK_IN) disable iff (RST_IN)
        (run && state_cur == HPD_PULSE && !cnt_end) |=> (state_cur == HPD_PULSE))
        else $error("HPD_PULSE left before the counter end");

    a_cnt_down : assert property (@(posedge CLK_IN) disable iff (RST_IN)
        !cnt_ld |=> (cnt <= $past(cnt)))      // Down only, or cleared
        else $error("interval counter rose without a load");

endmodule

`default_nettype wire

// ==== test/tb_dp_hpd.sv ====
////////////////////
// DP HPD testbench
// Directed tests over the local bus for the read path, plug,
// IRQ pulse, unplug, beat divisor and run clear
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_dp_hpd;

    import dp_hpd_pkg::*;

    localparam int P_BEAT_DIV  = 3;
    localparam int P_HMS_BEATS = 40;
    localparam int P_IPW_BEATS = 10;
    localparam int BEAT_CLKS   = P_BEAT_DIV + 1;    // Clocks per beat

    localparam logic [LB_ADR_W-1:0] ADR_CTL = {LB_BLK_HPD, 2'd0};
    localparam logic [LB_ADR_W-1:0] ADR_DIV = {LB_BLK_BEAT, 2'd0};

    logic                   CLK_IN = 1'b0;
    logic                   RST_IN;
    logic [LB_ADR_W-1:0]    lb_adr;
    logic                   lb_wr;
    logic                   lb_rd;
    logic [LB_DAT_W-1:0]    lb_din;
    logic [LB_DAT_W-1:0]    lb_dout;
    logic                   lb_vld;
    logic                   hpd;

    int                     cyc = 0;            // Rising edges since start
    int                     tests;
    int                     checks;
    int                     errors;
    integer                 seed;

    dp_hpd_top
    #(
        .P_BEAT_DIV  (P_BEAT_DIV),
        .P_HMS_BEATS (P_HMS_BEATS),
        .P_IPW_BEATS (P_IPW_BEATS)
    )
    dut0
    (
        .CLK_IN  (CLK_IN),
        .RST_IN  (RST_IN),
        .lb_adr  (lb_adr),
        .lb_wr   (lb_wr),
        .lb_rd   (lb_rd),
        .lb_din  (lb_din),
        .lb_dout (lb_dout),
        .lb_vld  (lb_vld),
        .hpd     (hpd)
    );

    // Assertions inside the HPD generator
    bind hpd_gen hpd_gen_properties u_props
    (
        .CLK_IN    (CLK_IN),
        .RST_IN    (RST_IN),
        .run       (run),
        .hpd       (hpd),
        .state_cur (state_cur),
        .cnt       (cnt),
        .cnt_ld    (cnt_ld),
        .cnt_end   (cnt_end)
    );

    always #4 CLK_IN = ~CLK_IN;                 // 8 ns period

    always @(posedge CLK_IN)
        cyc <= cyc + 1;

    // Control word from bit positions
    function automatic logic [LB_DAT_W-1:0] ctl_word(input logic run, unplug, plug, pulse);
        logic [LB_DAT_W-1:0] w;
        w             = '0;
        w[CTL_RUN]    = run;
        w[CTL_UNPLUG] = unplug;
        w[CTL_PLUG]   = plug;
        w[CTL_PULSE]  = pulse;
        return w;
    endfunction

    task automatic compare_word(input logic [LB_DAT_W-1:0] got, input logic [LB_DAT_W-1:0] exp,
                                input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Interval in clocks against beats, one beat period either way
    task automatic compare_interval(input int got, input int beats, input int clks,
                                    input string what);
        int lo;
        int hi;
        lo = beats * clks - clks;
        hi = beats * clks + clks;
        checks++;
        if (got < lo || got > hi)
        begin
            errors++;
            $display("FAIL %0t ns: %s took %0d clocks, expected %0d to %0d",
                     $time, what, got, lo, hi);
        end
    endtask

    // Called just after an edge; returns at the first sample with hpd at level
    task automatic wait_hpd(input logic level, input int limit, input string what);
        int n;
        n = 0;
        checks++;
        while (hpd !== level && n < limit)
        begin
            @(posedge CLK_IN);
            #1;
            n++;
        end
        if (hpd !== level)
        begin
            errors++;
            $display("Timed out after %0d clocks waiting for hpd to go %b in %s",
                     n, level, what);
        end
    endtask

    task automatic lb_write(input logic [LB_ADR_W-1:0] adr, input logic [LB_DAT_W-1:0] data);
        @(posedge CLK_IN);
        #1;
        lb_adr = adr;
        lb_din = data;
        lb_wr  = 1'b1;                          // One-cycle strobe
        @(posedge CLK_IN);
        #1;
        lb_wr  = 1'b0;
    endtask

    task automatic lb_read(input logic [LB_ADR_W-1:0] adr, output logic [LB_DAT_W-1:0] data);
        int n;
        @(posedge CLK_IN);
        #1;
        lb_adr = adr;
        lb_rd  = 1'b1;
        compare_bit(lb_vld, 1'b0, "lb_vld in read cycle");
        @(posedge CLK_IN);
        #1;
        lb_rd  = 1'b0;
        n      = 1;
        while (!lb_vld && n < 4)
        begin
            @(posedge CLK_IN);
            #1;
            n++;
        end
        checks++;
        if (!lb_vld)
        begin
            errors++;
            $display("Timed out waiting for lb_vld after a read of address %h", adr);
        end
        else if (n != 1)
        begin
            errors++;
            $display("FAIL %0t ns: lb_vld came %0d cycles after lb_rd, expected 1", $time, n);
        end
        data = lb_dout;
    endtask

    // Run clear, then plug from HPD_RST; rise is three edges after the write
    task automatic raise_hpd(input string what, output int rise);
        lb_write(ADR_CTL, ctl_word(1'b0, 1'b0, 1'b0, 1'b0));
        lb_write(ADR_CTL, ctl_word(1'b1, 1'b0, 1'b1, 1'b0));
        wait_hpd(1'b1, 3, what);
        rise = cyc;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before)
            $display("Test %0d %s: ok", tests, name);
        else
            $display("Test %0d %s: %0d errors", tests, name, errors - errs_before);
    endtask

    task automatic test_reset_read();
        int                  e0;
        logic [LB_DAT_W-1:0] d;
        e0 = errors;
        compare_bit(hpd, 1'b0, "hpd after reset");
        compare_bit(lb_vld, 1'b0, "lb_vld after reset");
        lb_read(ADR_CTL, d);
        compare_word(d, '0, "control reset value");
        lb_read(ADR_DIV, d);
        compare_word(d, P_BEAT_DIV, "divisor reset value");
        lb_read({LB_BLK_HPD, 2'd1}, d);         // Unused registers
        compare_word(d, LB_RD_DEFAULT, "unused HPD register");
        lb_read({LB_BLK_BEAT, 2'd3}, d);
        compare_word(d, LB_RD_DEFAULT, "unused beat register");
        lb_read({2'd2, 2'd0}, d);               // Unmapped blocks
        compare_word(d, LB_RD_DEFAULT, "block 2");
        lb_read({2'd3, 2'd1}, d);
        compare_word(d, LB_RD_DEFAULT, "block 3");
        compare_bit(hpd, 1'b0, "hpd after reads");
        report_test("reset and read path", e0);
    endtask

    task automatic test_plug();
        int                  e0;
        logic [LB_DAT_W-1:0] d;
        e0 = errors;
        lb_write(ADR_CTL, ctl_word(1'b1, 1'b0, 1'b1, 1'b0));
        wait_hpd(1'b1, 3, "plug");
        lb_read(ADR_CTL, d);
        compare_word(d, ctl_word(1'b1, 1'b0, 1'b0, 1'b0), "control after plug");
        report_test("plug", e0);
    endtask

    task automatic test_irq_pulse();
        int                  e0;
        int                  t_rise;
        int                  t_fall;
        logic [LB_DAT_W-1:0] d;
        e0 = errors;
        raise_hpd("IRQ pulse setup", t_rise);
        lb_write(ADR_CTL, ctl_word(1'b1, 1'b0, 1'b0, 1'b1));
        wait_hpd(1'b0, (P_HMS_BEATS + 4) * BEAT_CLKS, "IRQ pulse start");
        t_fall = cyc;
        compare_interval(t_fall - t_rise, P_HMS_BEATS, BEAT_CLKS, "spacing before IRQ pulse");
        wait_hpd(1'b1, (P_IPW_BEATS + 4) * BEAT_CLKS, "IRQ pulse end");
        compare_interval(cyc - t_fall, P_IPW_BEATS, BEAT_CLKS, "IRQ pulse width");
        lb_read(ADR_CTL, d);
        compare_word(d, ctl_word(1'b1, 1'b0, 1'b0, 1'b0), "control after IRQ pulse");
        report_test("IRQ pulse", e0);
    endtask

    task automatic test_unplug();
        int                  e0;
        int                  t_rise;
        logic [LB_DAT_W-1:0] d;
        e0 = errors;
        raise_hpd("unplug setup", t_rise);
        lb_write(ADR_CTL, ctl_word(1'b1, 1'b1, 1'b0, 1'b0));
        repeat (3) @(posedge CLK_IN);           // Request in the register and seen by the FSM
        #1;
        compare_bit(hpd, 1'b1, "hpd right after unplug request");   // Held by spacing
        wait_hpd(1'b0, (P_HMS_BEATS + 4) * BEAT_CLKS, "unplug");
        compare_interval(cyc - t_rise, P_HMS_BEATS, BEAT_CLKS, "spacing before unplug");
        lb_read(ADR_CTL, d);
        compare_word(d, ctl_word(1'b1, 1'b0, 1'b0, 1'b0), "control after unplug");
        compare_bit(hpd, 1'b0, "hpd after unplug");
        report_test("unplug", e0);
    endtask

    task automatic test_beat_div();
        int                  e0;
        int                  i;
        int                  div;
        int                  t_rise;
        int                  t_fall;
        logic [LB_DAT_W-1:0] d;
        e0 = errors;
        for (i = 0; i < 3; i++)
        begin
            div = 1 + int'($unsigned($random(seed)) % 6);          // Small divisor, 1 to 6
            lb_write(ADR_DIV, div);
            lb_read(ADR_DIV, d);
            compare_word(d, div, "divisor readback");
            raise_hpd("divisor setup", t_rise);
            lb_write(ADR_CTL, ctl_word(1'b1, 1'b0, 1'b0, 1'b1));
            wait_hpd(1'b0, (P_HMS_BEATS + 4) * (div + 1), "pulse start");
            t_fall = cyc;
            wait_hpd(1'b1, (P_IPW_BEATS + 4) * (div + 1), "pulse end");
            compare_interval(cyc - t_fall, P_IPW_BEATS, div + 1, "IRQ pulse width");
        end
        lb_write(ADR_DIV, P_BEAT_DIV);          // Back to the reset divisor
        report_test("beat divisor", e0);
    endtask

    task automatic test_run_clear();
        int                  e0;
        int                  t_rise;
        logic                seen;
        logic [LB_DAT_W-1:0] d;
        e0 = errors;

        // Clear while high, pin drops one edge after the register update
        raise_hpd("run clear setup", t_rise);
        lb_write(ADR_CTL, ctl_word(1'b0, 1'b0, 1'b0, 1'b0));
        wait_hpd(1'b0, 2, "run clear while high");

        // Clear in the middle of an IRQ pulse
        raise_hpd("mid pulse setup", t_rise);
        lb_write(ADR_CTL, ctl_word(1'b1, 1'b0, 1'b0, 1'b1));
        wait_hpd(1'b0, (P_HMS_BEATS + 4) * BEAT_CLKS, "pulse start");
        repeat (4 * BEAT_CLKS) @(posedge CLK_IN);
        lb_write(ADR_CTL, ctl_word(1'b0, 1'b0, 1'b0, 1'b0));
        seen = 1'b0;
        repeat (2 * P_IPW_BEATS * BEAT_CLKS)
        begin
            @(posedge CLK_IN);
            #1;
            seen = seen | hpd;                  // Pulse must not finish
        end
        compare_bit(seen, 1'b0, "hpd rise after run clear mid pulse");
        lb_read(ADR_CTL, d);
        compare_word(d, '0, "control after run clear");

        // Fresh plug and full spacing again
        raise_hpd("plug after run clear", t_rise);
        lb_write(ADR_CTL, ctl_word(1'b1, 1'b1, 1'b0, 1'b0));
        wait_hpd(1'b0, (P_HMS_BEATS + 4) * BEAT_CLKS, "unplug after run clear");
        compare_interval(cyc - t_rise, P_HMS_BEATS, BEAT_CLKS, "spacing after run clear");
        report_test("run clear", e0);
    endtask

    initial
    begin
        RST_IN = 1'b1;
        lb_adr = '0;
        lb_wr  = 1'b0;
        lb_rd  = 1'b0;
        lb_din = '0;
        tests  = 0;
        checks = 0;
        errors = 0;
        seed   = 32'hf7b15efb;

        repeat (5) @(posedge CLK_IN);
        #1;
        RST_IN = 1'b0;

        test_reset_read();
        test_plug();
        test_irq_pulse();
        test_unplug();
        test_beat_div();
        test_run_clear();

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
common/dp_hpd_pkg.sv
rtl/lb_decoder.sv
rtl/beat_gen.sv
hpd/hpd_gen.sv
rtl/dp_hpd_top.sv
test/hpd_gen_properties.sv
test/tb_dp_hpd.sv

// ==== Makefile ====
# Verilator build and run of the DP HPD testbench

SRCS := $(shell grep -v '^+' list.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_dp_hpd: list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_dp_hpd -Mdir obj_dir -f list.f

run: obj_dir/Vtb_dp_hpd
	./obj_dir/Vtb_dp_hpd > sim.log 2>&1; cat sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
